// File: dv/boot_tests.txt
# name op addr data, fields in hex. B: addr is the first byte index, data four stream bytes
# with the first byte in bits 31:24. W: host write to word addr. R: host read, data expected
img_00 B 00 37c10200
img_04 B 04 93810100
img_08 B 08 13050000
img_0c B 0c 97020000
img_10 B 10 93820200
img_14 B 14 73900230
img_18 B 18 6f000000
img_1c B 1c deadbeef
img_20 B 20 01234567
img_24 B 24 89abcdef
img_28 B 28 fedcba98
img_2c B 2c 76543210
img_30 B 30 c0ffee11
img_34 B 34 5a5aa5a5
img_38 B 38 0f1e2d3c
img_3c B 3c 4b5a6978
hw_a W 20 a5a50001
hw_b W 21 5a5a0002
hr_a R 20 a5a50001
hw_c W 20 0bad0003
hr_b R 21 5a5a0002
hr_c R 20 0bad0003
hw_d W 3f 12345678
hr_d R 3f 12345678

// File: list.f
design/boot_pkg.sv
design/req_queue.sv
design/boot_loader.sv
design/mem_arbiter.sv
design/word_ram.sv
design/boot_mem_top.sv
dv/boot_mem_assert.sv
dv/tb_boot_mem.sv

// File: dv/tb_boot_mem.sv
// boot memory subsystem testbench
// streams the image from the tests file, runs host traffic during the load,
// then reads the image back under response back-pressure

`timescale 1ns/10ps

module tb_boot_mem;

    logic               clk27mhz;
    logic               resetn;
    logic               byte_valid;
    logic [7:0]         byte_data;
    logic               byte_ready;
    logic               host_req_valid;
    boot_pkg::mem_req_t host_req;
    logic               host_req_ready;
    logic               host_resp_valid;
    boot_pkg::word_t    host_resp_data;
    logic               host_resp_ready;
    logic               done;

    int              max_wait = 400;                    // cycles allowed per wait loop
    logic [7:0]      img_bytes [boot_pkg::IMAGE_BYTES]; // image in stream order
    string           op_name [$];                       // host operations, file order
    string           op_kind [$];
    boot_pkg::addr_t op_addr [$];
    boot_pkg::word_t op_data [$];

    boot_mem_top i_dut (.*);

    bind mem_arbiter boot_mem_assert i_arb_chk (
        .clk27mhz       (clk27mhz),
        .resetn         (resetn),
        .load_req_valid (load_req_valid),
        .load_req_addr  (load_req.addr),
        .load_req_wdata (load_req.wdata),
        .q_req_valid    (q_req_valid),
        .q_req_ready    (q_req_ready),
        .q_req_we       (q_req.we),
        .ram_en         (ram_en),
        .ram_we         (ram_we),
        .ram_addr       (ram_addr),
        .ram_wdata      (ram_wdata),
        .rsp_valid      (rsp_valid),
        .done           (tb_boot_mem.i_dut.done)
    );

    always #10 clk27mhz = ~clk27mhz;    // 20 ns period

    task automatic report_timeout(input string what);
        $display("timeout while waiting for %s", what);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input boot_pkg::word_t expected,
                               input boot_pkg::word_t actual);
        if (expected !== actual) begin
            $display("mismatch %s expected %h actual %h", name, expected, actual);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    // byte k of the stream lands in word k/4, lane k%4
    function automatic boot_pkg::word_t image_word(input int w);
        boot_pkg::word_t wd;
        for (int l = 0; l < 4; l++) wd[8*l +: 8] = img_bytes[4*w + l];
        return wd;
    endfunction

    task automatic load_tests();
        int          fd;
        int          n;
        string       line;
        string       name;
        string       kind;
        logic [31:0] a;
        logic [31:0] d;
        fd = $fopen("dv/boot_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open the tests file dv/boot_tests.txt");
            $display("TEST FAILED");
            $fatal(1);
        end
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 0 && line.len() > 1 && line[0] != "#") begin
                n = $sscanf(line, "%s %s %h %h", name, kind, a, d);
                if (kind == "B") begin
                    for (int i = 0; i < 4; i++) img_bytes[a + i] = d[31 - 8*i -: 8];
                end else begin
                    op_name.push_back(name);
                    op_kind.push_back(kind);
                    op_addr.push_back(a[5:0]);
                    op_data.push_back(d);
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic send_byte(input logic [7:0] b, input int gap);
        int t;
        repeat (gap) @(negedge clk27mhz);
        @(negedge clk27mhz);
        byte_valid <= 1'b1;
        byte_data  <= b;
        t = 0;
        while (!byte_ready) begin
            if (t == max_wait) report_timeout("byte_ready");
            t++;
            @(negedge clk27mhz);
        end
        @(posedge clk27mhz);    // byte taken here
        @(negedge clk27mhz);
        byte_valid <= 1'b0;
    endtask

    task automatic send_host(input logic we, input boot_pkg::addr_t a,
                             input boot_pkg::word_t d, input int gap);
        int t;
        repeat (gap) @(negedge clk27mhz);
        @(negedge clk27mhz);
        host_req_valid <= 1'b1;
        host_req.we    <= we;
        host_req.addr  <= a;
        host_req.wdata <= d;
        t = 0;
        while (!host_req_ready) begin
            if (t == max_wait) report_timeout("host_req_ready");
            t++;
            @(negedge clk27mhz);
        end
        @(posedge clk27mhz);
        @(negedge clk27mhz);
        host_req_valid <= 1'b0;
    endtask

    // single outstanding read, response ready held high
    task automatic wait_response(input string name, input boot_pkg::word_t expected);
        int t;
        t = 0;
        @(negedge clk27mhz);
        while (!host_resp_valid) begin
            if (t == max_wait) report_timeout("a host read response");
            t++;
            @(negedge clk27mhz);
        end
        check_value(name, expected, host_resp_data);
        @(posedge clk27mhz);    // popped
    endtask

    initial begin
        int   t;
        int   got;
        logic rdy;
        clk27mhz        = 1'b0;
        resetn          = 1'b0;
        byte_valid      = 1'b0;
        byte_data       = '0;
        host_req_valid  = 1'b0;
        host_req        = '0;
        host_resp_ready = 1'b1;
        void'($urandom(99240));
        load_tests();
        repeat (4) @(negedge clk27mhz);
        resetn <= 1'b1;
        @(negedge clk27mhz);

        // ---------------------------------------------------------------------
        // idle state after reset
        // ---------------------------------------------------------------------
        check_value("reset_done", 0, done);
        check_value("reset_resp_valid", 0, host_resp_valid);
        check_value("reset_byte_ready", 1, byte_ready);
        check_value("reset_req_ready", 1, host_req_ready);

        // image stream and host traffic side by side, disjoint addresses
        fork
            for (int k = 0; k < boot_pkg::IMAGE_BYTES; k++) begin
                send_byte(img_bytes[k], $urandom_range(1, 3));
            end
            for (int j = 0; j < op_kind.size(); j++) begin
                send_host(op_kind[j] == "W", op_addr[j],
                          (op_kind[j] == "W") ? op_data[j] : '0, $urandom_range(0, 4));
                if (op_kind[j] == "R") wait_response(op_name[j], op_data[j]);
            end
        join

        t = 0;
        while (!done) begin
            if (t == max_wait) report_timeout("done after the last image byte");
            t++;
            @(negedge clk27mhz);
        end
        check_value("done_byte_ready", 0, byte_ready);

        // bytes past the image must stay stalled
        byte_valid <= 1'b1;
        byte_data  <= 8'hee;
        repeat (50) begin
            @(negedge clk27mhz);
            check_value("extra_byte", 0, byte_ready);
        end
        byte_valid <= 1'b0;

        // ---------------------------------------------------------------------
        // image readback, responses stalled at random
        // ---------------------------------------------------------------------
        fork
            for (int w = 0; w < boot_pkg::IMAGE_WORDS; w++) begin
                send_host(1'b0, w[5:0], '0, $urandom_range(0, 1));
            end
            begin
                got = 0;
                t   = 0;
                while (got < boot_pkg::IMAGE_WORDS) begin
                    @(negedge clk27mhz);
                    rdy = ($urandom_range(0, 2) != 0);
                    host_resp_ready <= rdy;
                    if (host_resp_valid && rdy) begin
                        check_value($sformatf("image_rd_%0d", got), image_word(got),
                                    host_resp_data);
                        got++;
                        t = 0;
                    end else if (t == max_wait) begin
                        report_timeout("an image read response");
                    end else begin
                        t++;
                    end
                end
            end
        join
        @(negedge clk27mhz);
        host_resp_ready <= 1'b1;

        $display("TEST OK");
        $finish;
    end

endmodule

// File: dv/boot_mem_assert.sv
// arbiter and response protocol checks
// bound into mem_arbiter from the testbench, done comes from the top level

`timescale 1ns/10ps

module boot_mem_assert (
    input logic            clk27mhz,
    input logic            resetn,
    input logic            load_req_valid,
    input boot_pkg::addr_t load_req_addr,
    input boot_pkg::word_t load_req_wdata,
    input logic            q_req_valid,
    input logic            q_req_ready,
    input logic            q_req_we,
    input logic            ram_en,
    input logic            ram_we,
    input boot_pkg::addr_t ram_addr,
    input boot_pkg::word_t ram_wdata,
    input logic            rsp_valid,
    input logic            done
);

    // loader wins whenever both peers want the memory
    a_load_first: assert property (@(posedge clk27mhz) disable iff (!resetn)
        load_req_valid && q_req_valid |-> !q_req_ready && ram_en && ram_we &&
            ram_addr == load_req_addr && ram_wdata == load_req_wdata)
        else $error("host granted over a valid loader request");

    // every response follows a host read grant one cycle earlier
    a_rsp_needs_read: assert property (@(posedge clk27mhz) disable iff (!resetn)
        rsp_valid |-> $past(q_req_valid && q_req_ready && !q_req_we))
        else $error("response raised with no read pending");

    // sticky until reset
    a_done_sticky: assert property (@(posedge clk27mhz) disable iff (!resetn)
        done |=> done)
        else $error("done fell while out of reset");

endmodule

// File: design/boot_mem_top.sv
// boot memory subsystem top
// byte loader and host port share one word memory through a priority arbiter,
// host traffic passes through a request queue and a response queue

`timescale 1ns/10ps

module boot_mem_top (
    input  logic               clk27mhz,
    input  logic               resetn,
    // byte stream in
    input  logic               byte_valid,
    input  logic [7:0]         byte_data,
    output logic               byte_ready,
    // host requests
    input  logic               host_req_valid,
    input  boot_pkg::mem_req_t host_req,
    output logic               host_req_ready,
    // host read responses
    output logic               host_resp_valid,
    output boot_pkg::word_t    host_resp_data,
    input  logic               host_resp_ready,
    output logic               done
);

    // loader to arbiter
    logic               load_req_valid;
    boot_pkg::mem_req_t load_req;
    logic               load_req_ready;
    // request queue to arbiter
    logic               q_req_valid;
    boot_pkg::mem_req_t q_req;
    logic               q_req_ready;
    // memory bus
    logic               ram_en;
    logic               ram_we;
    boot_pkg::addr_t    ram_addr;
    boot_pkg::word_t    ram_wdata;
    boot_pkg::word_t    ram_rdata;
    // arbiter to response queue
    logic               rsp_valid;
    boot_pkg::word_t    rsp_data;
    logic               rsp_ready;

    // ------------------------------------------------------------------------
    // loader and host queues
    // ------------------------------------------------------------------------
    boot_loader i_loader (
        .clk27mhz       (clk27mhz),
        .resetn         (resetn),
        .byte_valid     (byte_valid),
        .byte_data      (byte_data),
        .byte_ready     (byte_ready),
        .load_req_valid (load_req_valid),
        .load_req       (load_req),
        .load_req_ready (load_req_ready),
        .done           (done)
    );

    req_queue #(.payload_t(boot_pkg::mem_req_t)) i_req_q (
        .clk27mhz  (clk27mhz),
        .resetn    (resetn),
        .in_valid  (host_req_valid),
        .in_data   (host_req),
        .in_ready  (host_req_ready),
        .out_valid (q_req_valid),
        .out_data  (q_req),
        .out_ready (q_req_ready)
    );

    req_queue #(.payload_t(boot_pkg::word_t)) i_rsp_q (
        .clk27mhz  (clk27mhz),
        .resetn    (resetn),
        .in_valid  (rsp_valid),
        .in_data   (rsp_data),
        .in_ready  (rsp_ready),     // backpressure reaches the arbiter here
        .out_valid (host_resp_valid),
        .out_data  (host_resp_data),
        .out_ready (host_resp_ready)
    );

    // ------------------------------------------------------------------------
    // arbiter and memory
    // ------------------------------------------------------------------------
    mem_arbiter i_arb (
        .clk27mhz       (clk27mhz),
        .resetn         (resetn),
        .load_req_valid (load_req_valid),
        .load_req       (load_req),
        .load_req_ready (load_req_ready),
        .q_req_valid    (q_req_valid),
        .q_req          (q_req),
        .q_req_ready    (q_req_ready),
        .ram_en         (ram_en),
        .ram_we         (ram_we),
        .ram_addr       (ram_addr),
        .ram_wdata      (ram_wdata),
        .ram_rdata      (ram_rdata),
        .rsp_valid      (rsp_valid),
        .rsp_data       (rsp_data),
        .rsp_ready      (rsp_ready)
    );

    word_ram i_ram (
        .clk27mhz (clk27mhz),
        .en       (ram_en),
        .we       (ram_we),
        .addr     (ram_addr),
        .wdata    (ram_wdata),
        .rdata    (ram_rdata)
    );

endmodule

// File: design/word_ram.sv
// shared word memory
// single port, MEM_WORDS deep, registered read with one cycle of latency.
// write and read happen on the same enable edge

`timescale 1ns/10ps

module word_ram (
    input  logic            clk27mhz,
    input  logic            en,
    input  logic            we,
    input  boot_pkg::addr_t addr,
    input  boot_pkg::word_t wdata,
    output boot_pkg::word_t rdata
);

    // ------------------------------------------------------------------------
    // storage
    // ------------------------------------------------------------------------
    boot_pkg::word_t mem [boot_pkg::MEM_WORDS];    // contents undefined until loaded

    always_ff @(posedge clk27mhz) begin
        if (en) begin
            if (we) begin
                mem[addr] <= wdata;     // write at the enable edge
            end
            rdata <= mem[addr];         // old data on a write cycle
        end
    end

endmodule

// File: design/mem_arbiter.sv
// memory arbiter
// fixed priority between the loader and queued host requests, loader first.
// host reads are tracked one cycle and their data steered to the response queue

`timescale 1ns/10ps

module mem_arbiter (
    input  logic               clk27mhz,
    input  logic               resetn,
    // loader port, highest priority
    input  logic               load_req_valid,
    input  boot_pkg::mem_req_t load_req,
    output logic               load_req_ready,
    // host port through the request queue
    input  logic               q_req_valid,
    input  boot_pkg::mem_req_t q_req,
    output logic               q_req_ready,
    // memory side
    output logic               ram_en,
    output logic               ram_we,
    output boot_pkg::addr_t    ram_addr,
    output boot_pkg::word_t    ram_wdata,
    input  boot_pkg::word_t    ram_rdata,
    // read responses
    output logic               rsp_valid,
    output boot_pkg::word_t    rsp_data,
    input  logic               rsp_ready
);

    boot_pkg::mem_req_t sel_req;    // winning request
    logic               grant_load;
    logic               grant_host;
    logic               host_rd_ok; // room for a read response
    logic               read_pend;  // host read issued last cycle

    // ------------------------------------------------------------------------
    // grant logic
    // ------------------------------------------------------------------------
    assign load_req_ready = 1'b1;           // loader is never held off
    assign grant_load     = load_req_valid;

    // a read needs a free response slot and no read already in flight
    assign host_rd_ok  = rsp_ready & ~read_pend;
    assign q_req_ready = ~load_req_valid & (q_req.we | host_rd_ok);
    assign grant_host  = q_req_valid & q_req_ready;

    assign sel_req   = grant_load ? load_req : q_req;
    assign ram_en    = grant_load | grant_host;
    assign ram_we    = ram_en & sel_req.we;
    assign ram_addr  = sel_req.addr;
    assign ram_wdata = sel_req.wdata;

    // ------------------------------------------------------------------------
    // read tracking
    // ------------------------------------------------------------------------
    always_ff @(posedge clk27mhz) begin
        if (!resetn) begin
            read_pend <= 1'b0;
        end else begin
            read_pend <= grant_host & ~q_req.we;    // only host reads answer
        end
    end

    // ram data is valid one edge after the grant
    assign rsp_valid = read_pend;
    assign rsp_data  = ram_rdata;

endmodule

// File: design/boot_loader.sv
// boot image loader
// packs a byte stream into 32-bit little-endian words and writes them to
// consecutive memory addresses, raising done after the last image word

`timescale 1ns/10ps

module boot_loader (
    input  logic               clk27mhz,
    input  logic               resetn,
    // byte stream from the card reader
    input  logic               byte_valid,
    input  logic [7:0]         byte_data,
    output logic               byte_ready,
    // write requests toward the arbiter
    output logic               load_req_valid,
    output boot_pkg::mem_req_t load_req,
    input  logic               load_req_ready,
    output logic               done
);

    logic [1:0]      byte_cnt;   // lane of the next byte
    boot_pkg::word_t word_q;     // word being assembled
    boot_pkg::addr_t word_addr;  // address of the current word
    logic            byte_fire;
    logic            load_fire;
    logic            last_word;

    // ------------------------------------------------------------------------
    // handshakes
    // ------------------------------------------------------------------------

    // stall the byte source while a full word waits, and for good once done
    assign byte_ready = ~load_req_valid & ~done;
    assign byte_fire  = byte_valid & byte_ready;
    assign load_fire  = load_req_valid & load_req_ready;
    assign last_word  = (word_addr == boot_pkg::addr_t'(boot_pkg::IMAGE_WORDS - 1));

    // loader only ever writes
    assign load_req.we    = 1'b1;
    assign load_req.addr  = word_addr;
    assign load_req.wdata = word_q;

    // ------------------------------------------------------------------------
    // byte packing
    // ------------------------------------------------------------------------

    // assembly register, lane picked by the byte counter
    always_ff @(posedge clk27mhz) begin
        if (byte_fire) word_q[{byte_cnt, 3'b000} +: 8] <= byte_data;
    end

    always_ff @(posedge clk27mhz) begin
        if (!resetn) begin
            byte_cnt <= 2'd0;
        end else if (byte_fire) begin
            byte_cnt <= byte_cnt + 2'd1;    // wraps after lane 3
        end
    end

    // ------------------------------------------------------------------------
    // write sequencing
    // ------------------------------------------------------------------------
    always_ff @(posedge clk27mhz) begin
        if (!resetn) begin
            load_req_valid <= 1'b0;
            word_addr      <= '0;
            done           <= 1'b0;
        end else begin
            if (byte_fire && byte_cnt == 2'd3) begin
                load_req_valid <= 1'b1;     // fourth byte completes the word
            end else if (load_fire) begin
                load_req_valid <= 1'b0;
            end
            if (load_fire) begin
                word_addr <= word_addr + 1'b1;  // next sequential word
                if (last_word) done <= 1'b1;    // sticky until reset
            end
        end
    end

endmodule

// File: design/req_queue.sv
// two-entry valid/ready queue
// payload type comes in as a type parameter so one block carries requests and
// responses alike. an occupancy count keeps full throughput at depth 2

`timescale 1ns/10ps

module req_queue #(
    parameter type payload_t = boot_pkg::word_t
) (
    input  logic     clk27mhz,
    input  logic     resetn,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     in_ready,
    output logic     out_valid,
    output payload_t out_data,
    input  logic     out_ready
);

    payload_t   slot [2];   // storage, no reset needed
    logic       wr_ptr;     // next slot to fill
    logic       rd_ptr;     // oldest entry
    logic [1:0] count;      // 0, 1 or 2 entries
    logic       push;
    logic       pop;

    assign in_ready  = (count != 2'd2);     // accept while not full
    assign out_valid = (count != 2'd0);
    assign out_data  = slot[rd_ptr];

    assign push = in_valid & in_ready;
    assign pop  = out_valid & out_ready;

    // pointers and occupancy
    always_ff @(posedge clk27mhz) begin
        if (!resetn) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= 2'd0;
        end else begin
            if (push) wr_ptr <= ~wr_ptr;
            if (pop)  rd_ptr <= ~rd_ptr;
            case ({push, pop})
                2'b10:   count <= count + 2'd1;
                2'b01:   count <= count - 2'd1;
                default: count <= count;    // idle or push+pop together
            endcase
        end
    end

    always_ff @(posedge clk27mhz) begin
        if (push) slot[wr_ptr] <= in_data;
    end

endmodule

// File: design/boot_pkg.sv
// boot loader package
// word, address and request types shared by the loader, the arbiter and the memory,
// plus the boot image size constants

package boot_pkg;

    // ------------------------------------------------------------------------
    // memory geometry
    // ------------------------------------------------------------------------
    localparam int MEM_WORDS  = 64;                 // depth of the shared word memory
    localparam int ADDR_BITS  = $clog2(MEM_WORDS);  // 6 bits of word address
    localparam int WORD_BITS  = 32;
    localparam int WORD_BYTES = WORD_BITS / 8;      // bytes per word, little endian

    // ------------------------------------------------------------------------
    // boot image size
    // ------------------------------------------------------------------------
    localparam int IMAGE_BYTES = 64;                       // fixed image length
    localparam int IMAGE_WORDS = IMAGE_BYTES / WORD_BYTES; // 16 words written by the loader

    // ------------------------------------------------------------------------
    // types
    // ------------------------------------------------------------------------

    // one memory word, byte 0 sits in bits 7:0
    typedef logic [WORD_BITS-1:0] word_t;

    // word address into the shared memory
    typedef logic [ADDR_BITS-1:0] addr_t;

    // memory request as carried by the loader, the host queue and the arbiter
    typedef struct packed {
        logic  we;    // 1 = write, 0 = read
        addr_t addr;  // word address
        word_t wdata; // write data, don't care on reads
    } mem_req_t;

endpackage
